/* src/pll_rcfg_defs.svh */
// PLL reconfiguration parameters
// Register map size, bus widths and agent wait length
// shared by the command block, agent, latch and top

`ifndef PLL_RCFG_DEFS_SVH
`define PLL_RCFG_DEFS_SVH

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define RCFG_ADDR_W 4       // Word address into register map
`define RCFG_NUM_REGS 16    // Reconfiguration registers

// --------------------------------------------------
// Data path
// --------------------------------------------------
`define RCFG_DATA_W 32      // Register and bus data width

// --------------------------------------------------
// Agent timing
// --------------------------------------------------
// Waitrequest stays high for this many cycles at the start of each access
`define RCFG_WAIT_CYCLES 2

`endif

/* src/pll_rcfg_pkg.sv */
// PLL reconfiguration types
// One-hot controller state and host command opcode

package pll_rcfg_pkg;

   // Bit positions of the one-hot state vector
   typedef enum int {
      RESET_BIT,           // Power on default
      IDLE_BIT,
      WRITE_BIT,
      READ_BIT,
      EPILOGUE_BIT,
      ERROR_START_BIT,
      MAX_STATE_BIT        // Count of states
   } rcfg_state_idx_e;

   // Controller state, exactly one bit set
   typedef enum logic [MAX_STATE_BIT-1:0] {
      RESET       = 6'b000001,  // Held while in reset
      IDLE        = 6'b000010,  // Waiting for sequence change
      WRITE       = 6'b000100,  // amm_write high
      READ        = 6'b001000,  // amm_read high
      EPILOGUE    = 6'b010000,  // Latch enable high
      ERROR_START = 6'b100000   // Restart during access, fatal
   } rcfg_state_e;

   // Host command opcode
   typedef enum logic {
      RCFG_READ  = 1'b0,
      RCFG_WRITE = 1'b1
   } rcfg_op_e;

endpackage

/* src/rcfg_cmd_csr.sv */
// Host command register for PLL reconfiguration
// Captures opcode, address and write data on each cmd_valid
// and announces the command by stepping a 2-bit sequence number

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module rcfg_cmd_csr
   import pll_rcfg_pkg::*;
(
   // Clock and reset
   input  logic                    clk,
   input  logic                    rst_n_dly,   // Sync, active low

   // Host side
   input  logic                    cmd_valid,   // One cycle strobe
   input  rcfg_op_e                cmd_op,      // Read or write
   input  logic [`RCFG_ADDR_W-1:0] cmd_addr,    // Register address
   input  logic [`RCFG_DATA_W-1:0] cmd_wdata,   // Write data

   // Controller side
   output logic [1:0]              rcfg_seq,    // Change starts controller
   output rcfg_op_e                rcfg_op,     // Registered opcode

   // Agent side
   output logic [`RCFG_ADDR_W-1:0] rcfg_addr,   // Registered address
   output logic [`RCFG_DATA_W-1:0] rcfg_wdata   // Registered write data
);

// Sequence counter next value
logic [1:0] seq_next;

//--------------------------------------------------
// Sequence counter
//--------------------------------------------------

// Wraps modulo 4
assign seq_next = rcfg_seq + 2'd1;

always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      rcfg_seq <= 2'd0;
   end else if (cmd_valid) begin
      // Steps even with an access in flight
      // Controller flags that case as an error
      rcfg_seq <= seq_next;
   end
end

//--------------------------------------------------
// Command register
//--------------------------------------------------

// Opcode is control, cleared to read
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      rcfg_op <= RCFG_READ;
   end else if (cmd_valid) begin
      rcfg_op <= cmd_op;         // Latest command wins
   end
end

// Address and data payload
always_ff @(posedge clk) begin
   if (cmd_valid) begin
      rcfg_addr  <= cmd_addr;    // Held until next command
      rcfg_wdata <= cmd_wdata;   // Unused by reads
   end
end

// Payload and opcode land in the same edge as the sequence step
// so the controller sees a stable command one cycle later

endmodule

/* src/rcfg_fsm.sv */
// PLL reconfiguration controller
// One-hot FSM, starts on a sequence number change and runs one
// read or write on the MM agent, assumes read latency of one.
// A restart during an access is a fatal sticky error

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module rcfg_fsm
   import pll_rcfg_pkg::*;
(
   // Clock and reset
   input  logic       clk,
   input  logic       rst_n_dly,           // Sync, active low

   // Command block
   input  logic [1:0] rcfg_seq,            // Sequence change starts FSM
   input  rcfg_op_e   rcfg_op,             // Read or write

   // MM agent
   input  logic       amm_waitrequest,     // Stretches access
   output logic       amm_read,            // Registered read strobe
   output logic       amm_write,           // Registered write strobe

   // Readback latch
   output logic       enable_read_latch,   // Cycle after acceptance

   // Status
   output logic       error                // Sticky, reset clears
);

logic [1:0]  rcfg_seq_dly;                 // Previous sequence number
logic        start_cmd;                    // Sequence changed
logic        write_cmd;                    // Registered opcode, 1 for write

logic        amm_read_next;
logic        amm_write_next;
logic        enable_read_latch_next;
logic        error_next;

rcfg_state_e state;
rcfg_state_e next_state;

//--------------------------------------------------
// Input registers
//--------------------------------------------------
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      rcfg_seq_dly <= 2'd0;
      start_cmd    <= 1'b0;
      write_cmd    <= 1'b0;
   end else begin
      rcfg_seq_dly <= rcfg_seq;
      start_cmd    <= |(rcfg_seq_dly ^ rcfg_seq);   // One cycle per change
      write_cmd    <= (rcfg_op == RCFG_WRITE);
   end
end

//--------------------------------------------------
// State machine
//--------------------------------------------------
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      state <= RESET;
   end else begin
      state <= next_state;
   end
end

always_comb begin
   // Strobes default low
   amm_read_next          = 1'b0;
   amm_write_next         = 1'b0;
   enable_read_latch_next = 1'b0;
   error_next             = 1'b0;
   next_state             = state;

   unique case (1'b1)
      state[RESET_BIT] : begin
         // One cycle after reset release
         next_state = IDLE;
      end
      state[IDLE_BIT] : begin
         if (start_cmd) begin
            amm_write_next = write_cmd;     // Strobe rises with state
            amm_read_next  = ~write_cmd;
            next_state     = write_cmd ? WRITE : READ;
         end
      end
      state[WRITE_BIT], state[READ_BIT] : begin
         if (start_cmd) begin
            next_state = ERROR_START;       // Restart mid access
         end else if (~amm_waitrequest) begin
            enable_read_latch_next = 1'b1;  // Accepted, readdata next
            next_state             = EPILOGUE;
         end else begin
            amm_write_next = state[WRITE_BIT];   // Hold strobe
            amm_read_next  = state[READ_BIT];
         end
      end
      state[EPILOGUE_BIT] : begin
         // Latch enable high this cycle
         next_state = start_cmd ? ERROR_START : IDLE;
      end
      state[ERROR_START_BIT] : begin
         error_next = 1'b1;                 // Parked until reset
      end
      default : next_state = RESET;         // Illegal encoding
   endcase
end

//--------------------------------------------------
// Output registers
//--------------------------------------------------
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      amm_read          <= 1'b0;
      amm_write         <= 1'b0;
      enable_read_latch <= 1'b0;
      error             <= 1'b0;
   end else begin
      amm_read          <= amm_read_next;
      amm_write         <= amm_write_next;
      enable_read_latch <= enable_read_latch_next;
      error             <= error_next;   // Follows parked ERROR_START
   end
end

endmodule

/* src/pll_rcfg_regs.sv */
// PLL reconfiguration register agent
// Avalon-MM style target holding the PLL reconfiguration registers.
// Waitrequest is held high for the first cycles of every access,
// read data follows acceptance by one cycle

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module pll_rcfg_regs (
   // Clock and reset
   input  logic                    clk,
   input  logic                    rst_n_dly,        // Sync, active low

   // MM target
   input  logic                    amm_read,
   input  logic                    amm_write,
   input  logic [`RCFG_ADDR_W-1:0] amm_address,
   input  logic [`RCFG_DATA_W-1:0] amm_writedata,
   output logic                    amm_waitrequest,  // Stretches access
   output logic [`RCFG_DATA_W-1:0] amm_readdata      // Valid after accept
);

localparam int CNT_W = ($clog2(`RCFG_WAIT_CYCLES + 1) > 0) ?
                       $clog2(`RCFG_WAIT_CYCLES + 1) : 1;

logic [`RCFG_DATA_W-1:0] regs [`RCFG_NUM_REGS];   // Reconfiguration regs
logic [CNT_W-1:0]        wait_cnt;                 // Cycles waited so far
logic                    access;                   // Strobe high
logic                    accept;                   // Strobe and no wait

//--------------------------------------------------
// Waitrequest stretch
//--------------------------------------------------
assign access          = amm_read | amm_write;
assign amm_waitrequest = access & (wait_cnt < CNT_W'(`RCFG_WAIT_CYCLES));
assign accept          = access & ~amm_waitrequest;

always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      wait_cnt <= '0;
   end else if (accept | ~access) begin
      wait_cnt <= '0;                 // Ready for next access
   end else begin
      wait_cnt <= wait_cnt + 1'b1;    // Still stretching
   end
end

//--------------------------------------------------
// Register file
//--------------------------------------------------
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
         regs[i] <= '0;
      end
   end else if (accept && amm_write) begin
      regs[amm_address] <= amm_writedata;   // Write lands on accept
   end
end

// Read data one cycle after accept
// A write returns the value it just stored
always_ff @(posedge clk) begin
   if (accept) begin
      amm_readdata <= amm_write ? amm_writedata : regs[amm_address];
   end
end

endmodule

/* src/rcfg_read_latch.sv */
// Readback latch
// Captures agent read data on the controller's enable and
// raises done one cycle later with the captured value

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module rcfg_read_latch (
   // Clock and reset
   input  logic                    clk,
   input  logic                    rst_n_dly,          // Sync, active low

   // Controller and agent
   input  logic                    enable_read_latch,  // Capture strobe
   input  logic [`RCFG_DATA_W-1:0] amm_readdata,       // Agent read data

   // Host side
   output logic [`RCFG_DATA_W-1:0] rd_data,            // Held to next capture
   output logic                    done                // Completion strobe
);

//--------------------------------------------------
// Capture and completion
//--------------------------------------------------
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      rd_data <= '0;
   end else if (enable_read_latch) begin
      rd_data <= amm_readdata;         // Readdata valid this cycle
   end
end

// Done lines up with the new rd_data
always_ff @(posedge clk) begin
   if (~rst_n_dly) begin
      done <= 1'b0;
   end else begin
      done <= enable_read_latch;
   end
end

endmodule

/* src/user_clk_rcfg_top.sv */
// User clock PLL reconfiguration subsystem
// Command block, controller, register agent and readback latch

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module user_clk_rcfg_top
   import pll_rcfg_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_dly,   // Sync, active low

   // Host command
   input  logic                    cmd_valid,
   input  rcfg_op_e                cmd_op,
   input  logic [`RCFG_ADDR_W-1:0] cmd_addr,
   input  logic [`RCFG_DATA_W-1:0] cmd_wdata,

   // Host response
   output logic [`RCFG_DATA_W-1:0] rd_data,
   output logic                    done,        // One pulse per command
   output logic                    error        // Sticky fatal error
);

// Command block outputs
logic [1:0]              rcfg_seq;
rcfg_op_e                rcfg_op;
logic [`RCFG_ADDR_W-1:0] rcfg_addr;
logic [`RCFG_DATA_W-1:0] rcfg_wdata;

// MM bus between controller and agent
logic                    amm_read;
logic                    amm_write;
logic                    amm_waitrequest;
logic [`RCFG_DATA_W-1:0] amm_readdata;
logic                    enable_read_latch;

//--------------------------------------------------
// Instances
//--------------------------------------------------
rcfg_cmd_csr i_cmd_csr (
   .clk, .rst_n_dly, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata,
   .rcfg_seq, .rcfg_op, .rcfg_addr, .rcfg_wdata
);

rcfg_fsm i_fsm (
   .clk, .rst_n_dly, .rcfg_seq, .rcfg_op, .amm_waitrequest,
   .amm_read, .amm_write, .enable_read_latch, .error
);

pll_rcfg_regs i_regs (
   .clk, .rst_n_dly, .amm_read, .amm_write,
   .amm_address   (rcfg_addr),
   .amm_writedata (rcfg_wdata),
   .amm_waitrequest, .amm_readdata
);

rcfg_read_latch i_read_latch (
   .clk, .rst_n_dly, .enable_read_latch, .amm_readdata, .rd_data, .done
);

endmodule

/* sim/user_clk_rcfg_asserts.sv */
// Controller bus checks
// Concurrent assertions bound into the reconfiguration FSM

`timescale 1ns/1ns

module user_clk_rcfg_asserts (
   input logic clk,
   input logic rst_n_dly,
   input logic amm_read,
   input logic amm_write,
   input logic amm_waitrequest,
   input logic start_cmd,           // Restart ends an access early
   input logic enable_read_latch,
   input logic error
);

a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n_dly)
   !(amm_read && amm_write)) else $error("read and write high together");

// Waitrequest holds the access open
a_hold_read : assert property (@(posedge clk) disable iff (!rst_n_dly)
   (amm_read && amm_waitrequest && !start_cmd) |=> amm_read)
   else $error("read strobe dropped under waitrequest");

a_hold_write : assert property (@(posedge clk) disable iff (!rst_n_dly)
   (amm_write && amm_waitrequest && !start_cmd) |=> amm_write)
   else $error("write strobe dropped under waitrequest");

a_error_sticky : assert property (@(posedge clk) disable iff (!rst_n_dly)
   error |=> error) else $error("error fell without reset");

a_latch_pulse : assert property (@(posedge clk) disable iff (!rst_n_dly)
   enable_read_latch |=> !enable_read_latch) else $error("latch enable wider than a cycle");

endmodule

bind rcfg_fsm user_clk_rcfg_asserts i_asserts (
   .clk(clk), .rst_n_dly(rst_n_dly), .amm_read(amm_read), .amm_write(amm_write),
   .amm_waitrequest(amm_waitrequest), .start_cmd(start_cmd),
   .enable_read_latch(enable_read_latch), .error(error)
);

/* sim/user_clk_rcfg_tb.sv */
// Testbench for the user clock PLL reconfiguration subsystem
// Runs test lines from a data file against the DUT and a model
// register array, LCG data for RAND fields

`timescale 1ns/1ns

`include "pll_rcfg_defs.svh"

module user_clk_rcfg_tb
   import pll_rcfg_pkg::*;
;

localparam int NAME_W  = 8*24;    // Test name field
localparam int TOK_W   = 8*12;    // Op, data and expect fields
localparam int TIMEOUT = 50;      // Cycles per wait

logic                    clk;
logic                    rst_n_dly;
logic                    cmd_valid;
rcfg_op_e                cmd_op;
logic [`RCFG_ADDR_W-1:0] cmd_addr;
logic [`RCFG_DATA_W-1:0] cmd_wdata;
logic [`RCFG_DATA_W-1:0] rd_data;
logic                    done;
logic                    error;

logic [`RCFG_DATA_W-1:0] model [`RCFG_NUM_REGS];   // Expected register contents
logic [31:0]             lcg_state;
int                      fd;

user_clk_rcfg_top i_dut (
   .clk, .rst_n_dly, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata,
   .rd_data, .done, .error
);

initial begin
   clk = 1'b0;
   forever #10 clk = ~clk;       // 20 ns period
end

//--------------------------------------------------
// Helpers
//--------------------------------------------------
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

task automatic abort_run(input logic [NAME_W-1:0] name, input string reason);
   $display("Test %0s stopped: %0s", name, reason);
   $display("FAIL: see errors above");
   $fatal(1, "Simulation stopped on error");
endtask

task automatic compare_val(input logic [NAME_W-1:0] name, input logic [31:0] expected,
                           input logic [31:0] actual);
   if (expected !== actual) begin
      $display("FAIL %0s expected %h actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "Value mismatch");
   end
endtask

task automatic apply_reset();
   @(posedge clk);
   rst_n_dly <= 1'b0;
   repeat (2) @(posedge clk);    // Held two cycles
   rst_n_dly <= 1'b1;
   for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
      model[i] = '0;             // Agent clears its registers
   end
endtask

task automatic issue_cmd(input rcfg_op_e op, input logic [`RCFG_ADDR_W-1:0] addr,
                         input logic [`RCFG_DATA_W-1:0] data);
   @(posedge clk);
   cmd_valid <= 1'b1;
   cmd_op    <= op;
   cmd_addr  <= addr;
   cmd_wdata <= data;
   @(posedge clk);
   cmd_valid <= 1'b0;            // Single cycle strobe
endtask

task automatic wait_done(input logic [NAME_W-1:0] name);
   int cycles;
   cycles = 0;
   @(negedge clk);
   while (!done) begin
      if (cycles == TIMEOUT) abort_run(name, "no done pulse before timeout");
      cycles++;
      @(negedge clk);
   end
endtask

// Two strobes on back to back cycles, second lands mid access
task automatic check_restart_error(input logic [NAME_W-1:0] name,
                                   input logic [`RCFG_ADDR_W-1:0] addr);
   int cycles;
   cycles = 0;
   @(posedge clk);
   cmd_valid <= 1'b1;
   cmd_op    <= RCFG_READ;
   cmd_addr  <= addr;
   @(posedge clk);
   cmd_addr  <= addr + 1'b1;     // Second pulse
   @(posedge clk);
   cmd_valid <= 1'b0;
   @(negedge clk);
   while (!error) begin
      if (cycles == TIMEOUT) abort_run(name, "error did not rise before timeout");
      cycles++;
      @(negedge clk);
   end
   repeat (TIMEOUT) begin         // Sticky, and no done
      @(negedge clk);
      compare_val(name, 32'h1, {31'h0, error});
      compare_val(name, 32'h0, {31'h0, done});
   end
endtask

task automatic run_line(input logic [NAME_W-1:0] name, input logic [TOK_W-1:0] op_s,
                        input logic [`RCFG_ADDR_W-1:0] addr, input logic [TOK_W-1:0] data_s,
                        input logic [TOK_W-1:0] exp_s);
   logic [31:0] data;
   logic [31:0] expected;
   rcfg_op_e    op;
   data     = 32'h0;
   expected = 32'h0;
   if (data_s == "RAND") data = lcg_next();
   else if (data_s != "-") void'($sscanf(data_s, "%h", data));
   if (op_s == "RST") begin
      apply_reset();
   end else if (op_s == "ERR") begin
      check_restart_error(name, addr);
   end else if (op_s == "RD" || op_s == "WR") begin
      op = (op_s == "WR") ? RCFG_WRITE : RCFG_READ;
      if (op == RCFG_WRITE) model[addr] = data;
      issue_cmd(op, addr, data);
      wait_done(name);
      if (exp_s == "MODEL") expected = model[addr];    // Write shows stored value
      else void'($sscanf(exp_s, "%h", expected));
      compare_val(name, expected, rd_data);
      @(negedge clk);
      compare_val(name, 32'h0, {31'h0, done});         // One cycle pulse
      compare_val(name, 32'h0, {31'h0, error});
   end else begin
      abort_run(name, "unknown operation in test file");
   end
endtask

//--------------------------------------------------
// Main sequence
//--------------------------------------------------
initial begin
   logic [NAME_W-1:0] name;
   logic [TOK_W-1:0]  op_s;
   logic [TOK_W-1:0]  data_s;
   logic [TOK_W-1:0]  exp_s;
   logic [31:0]       addr_v;
   int                n;
   int                c;
   rst_n_dly = 1'b0;
   cmd_valid = 1'b0;
   cmd_op    = RCFG_READ;
   cmd_addr  = '0;
   cmd_wdata = '0;
   lcg_state = 32'hf074_0c92;
   apply_reset();
   fd = $fopen("sim/user_clk_rcfg_tests.txt", "r");
   if (fd == 0) abort_run("setup", "cannot open the test data file");
   while ($fscanf(fd, "%s", name) == 1) begin
      if (name == "#") begin
         c = $fgetc(fd);                      // Skip comment line
         while (c != 10 && c != -1) c = $fgetc(fd);
      end else begin
         n = $fscanf(fd, "%s %h %s %s", op_s, addr_v, data_s, exp_s);
         if (n != 4) abort_run(name, "malformed line in test file");
         run_line(name, op_s, addr_v[`RCFG_ADDR_W-1:0], data_s, exp_s);
      end
   end
   $fclose(fd);
   $display("PASS: all tests");
   $finish;
end

endmodule

/* sim/user_clk_rcfg_tests.txt */
# name op addr data expect, op is RD WR ERR or RST, fields in hex
# data RAND takes the next LCG value, expect MODEL takes the model array, - is unused
rd_reset_a0 RD 0 - 00000000
rd_reset_af RD f - 00000000
wr_a3 WR 3 12345678 12345678
rd_a3 RD 3 - 12345678
wr_rand_a5 WR 5 RAND MODEL
rd_rand_a5 RD 5 - MODEL
wr_a6 WR 6 cafef00d MODEL
rd_a5_again RD 5 - MODEL
rd_a3_again RD 3 - 12345678
wr_rand_a0 WR 0 RAND MODEL
wr_rand_af WR f RAND MODEL
rd_a6 RD 6 - cafef00d
rd_a0 RD 0 - MODEL
rd_af RD f - MODEL
err_restart ERR 2 - -
rst_clear RST 0 - -
rd_after_rst RD 3 - 00000000

/* compile.f */
+incdir+src
src/pll_rcfg_pkg.sv
src/rcfg_cmd_csr.sv
src/rcfg_fsm.sv
src/pll_rcfg_regs.sv
src/rcfg_read_latch.sv
src/user_clk_rcfg_top.sv
sim/user_clk_rcfg_asserts.sv
sim/user_clk_rcfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reconfiguration testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module user_clk_rcfg_tb \
   -o sim_bin || { echo "build failed"; exit 1; }
./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
[ "$status" -eq 0 ] && grep -q "PASS: all tests" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"
